//--- logic/breakout_macros.svh
`ifndef BREAKOUT_MACROS_SVH
`define BREAKOUT_MACROS_SVH

// screen size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// paddle is two rows high
`define PADDLE_Y 110
`define PADDLE_W 16
`define PADDLE_X0 76

// ball start, just above the paddle
`define BALL_X0 80
`define BALL_Y0 108

`define BLOCK_W 8
`define BLOCK_H 4
`define NUM_BLOCKS 10

// clocks per frame, well above one frame of painting
`define FRAME_TICKS 1024

`endif

//--- logic/breakout_pkg.sv
`default_nettype none
`include "breakout_macros.svh"

package breakout_pkg;

	// 1 bit per rgb channel
	typedef enum logic [2:0] {
		BLACK = 3'b000,
		BLUE  = 3'b001,
		CYAN  = 3'b011,
		RED   = 3'b100,
		WHITE = 3'b111
	} colour_t;

	typedef struct packed {
		logic [7:0] x;
		logic [6:0] y;
	} coord_t;

	typedef struct packed {
		coord_t  pos;
		colour_t colour;
	} pixel_t;

	typedef struct packed {
		coord_t     origin;
		logic [7:0] w;
		logic [6:0] h;
		colour_t    colour;
	} rect_t;

	typedef enum logic [3:0] {
		S_CLEAR,
		S_INTRO_PAD,
		S_INTRO_BALL,
		S_IDLE,
		S_BLK_CHECK,
		S_BLK_PAINT,
		S_PAD_ERASE,
		S_PAD_MOVE,
		S_PAD_PAINT,
		S_BALL_ERASE,
		S_BALL_MOVE,
		S_BALL_PAINT,
		S_WIN_CHECK,
		S_FILL_RED,
		S_OVER
	} game_state_t;

	typedef struct packed {
		coord_t  origin;
		colour_t colour;
	} block_def_t;

	localparam block_def_t block_layout [`NUM_BLOCKS] = '{
		'{'{8'd34, 7'd30}, RED},
		'{'{8'd46, 7'd30}, RED},
		'{'{8'd58, 7'd30}, RED},
		'{'{8'd88, 7'd38}, CYAN},
		'{'{8'd100, 7'd38}, CYAN},
		'{'{8'd112, 7'd38}, CYAN},
		'{'{8'd124, 7'd38}, CYAN},
		'{'{8'd34, 7'd45}, BLUE},
		'{'{8'd46, 7'd45}, BLUE},
		'{'{8'd58, 7'd45}, BLUE}
	};

endpackage

`default_nettype wire

//--- logic/game_fsm.sv
`default_nettype none
`include "breakout_macros.svh"

module game_fsm (
	input  wire logic                 CLOCK_50,
	input  wire logic                 rst,
	input  wire logic                 new_game,
	input  wire logic                 paint_done,
	input  wire logic                 miss,
	input  wire logic                 all_clear,
	input  wire breakout_pkg::coord_t paddle_pos,
	input  wire breakout_pkg::coord_t ball_pos,
	input  wire breakout_pkg::rect_t  block_rect,
	output logic                      paint_start,
	output breakout_pkg::rect_t       paint_req,
	output logic                      init,
	output logic                      respawn,
	output logic                      paddle_step,
	output logic                      ball_step,
	output logic                      check,
	output logic [3:0]                block_idx,
	output logic                      game_over
);
	import breakout_pkg::*;

	localparam int TICK_W = $clog2(`FRAME_TICKS);

	game_state_t state, paint_next;
	logic [TICK_W-1:0] tick_cnt;
	logic frame_tick, busy, restart, win, last_block;
	rect_t req_next;

	function automatic rect_t make_rect(coord_t o, logic [7:0] w, logic [6:0] h, colour_t c);
		return '{o, w, h, c};
	endfunction

	assign frame_tick = (tick_cnt == TICK_W'(`FRAME_TICKS - 1));
	assign last_block = (block_idx == 4'(`NUM_BLOCKS - 1));

	// new game only taken between frames or after game over
	assign restart = new_game && (state == S_IDLE || state == S_OVER);
	assign win = all_clear && (state == S_WIN_CHECK);
	assign respawn = restart || win;
	assign init = respawn;
	assign check = (state == S_BLK_CHECK);
	assign paddle_step = (state == S_PAD_MOVE);
	assign ball_step = (state == S_BALL_MOVE);

	always_ff @(posedge CLOCK_50) begin
		if (rst || frame_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// what the current paint state draws, and where it goes when done
	always_comb begin
		req_next = make_rect(ball_pos, 8'd1, 7'd1, WHITE);
		paint_next = S_IDLE;
		case (state)
			S_CLEAR: begin
				req_next = make_rect('0, 8'(`SCREEN_W), 7'(`SCREEN_H), BLACK);
				paint_next = S_INTRO_PAD;
			end
			S_FILL_RED: begin
				req_next = make_rect('0, 8'(`SCREEN_W), 7'(`SCREEN_H), RED);
				paint_next = S_OVER;
			end
			S_BLK_PAINT: begin
				req_next = block_rect; // black once dead
				paint_next = last_block ? S_PAD_ERASE : S_BLK_CHECK;
			end
			S_PAD_ERASE: begin
				req_next = make_rect(paddle_pos, 8'(`PADDLE_W), 7'd2, BLACK);
				paint_next = S_PAD_MOVE;
			end
			S_PAD_PAINT, S_INTRO_PAD: begin
				req_next = make_rect(paddle_pos, 8'(`PADDLE_W), 7'd2, WHITE);
				paint_next = (state == S_INTRO_PAD) ? S_INTRO_BALL : S_BALL_ERASE;
			end
			S_BALL_ERASE: begin
				req_next = make_rect(ball_pos, 8'd1, 7'd1, BLACK);
				paint_next = S_BALL_MOVE;
			end
			S_BALL_PAINT: paint_next = S_WIN_CHECK;
			default: paint_next = S_IDLE;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= S_CLEAR;
			busy <= 1'b0;
			paint_start <= 1'b0;
			block_idx <= '0;
			game_over <= 1'b0;
		end else begin
			paint_start <= 1'b0;
			if (restart) begin
				state <= S_CLEAR;
				game_over <= 1'b0;
			end else begin
				case (state)
					S_IDLE: begin
						if (frame_tick) begin
							block_idx <= '0;
							state <= S_BLK_CHECK;
						end
					end
					S_BLK_CHECK: state <= S_BLK_PAINT;
					S_PAD_MOVE: state <= S_PAD_PAINT;
					S_BALL_MOVE: state <= S_BALL_PAINT;
					S_WIN_CHECK: state <= win ? S_CLEAR : S_IDLE;
					S_OVER: state <= S_OVER; // held until new_game
					default: begin
						if (!busy && state == S_BALL_PAINT && miss) begin
							state <= S_FILL_RED; // ball fell past the bottom
						end else if (!busy) begin
							paint_start <= 1'b1;
							paint_req <= req_next;
							busy <= 1'b1;
						end else if (paint_done) begin
							busy <= 1'b0;
							state <= paint_next;
							if (state == S_BLK_PAINT)
								block_idx <= last_block ? 4'd0 : block_idx + 4'd1;
							if (state == S_FILL_RED)
								game_over <= 1'b1;
						end
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/ball_paddle.sv
`default_nettype none
`include "breakout_macros.svh"

module ball_paddle (
	input  wire logic             CLOCK_50,
	input  wire logic             rst,
	input  wire logic             init,
	input  wire logic             paddle_step,
	input  wire logic             ball_step,
	input  wire logic             hit,
	input  wire logic             key_left,
	input  wire logic             key_right,
	output breakout_pkg::coord_t  paddle_pos,
	output breakout_pkg::coord_t  ball_pos,
	output logic                  miss
);
	import breakout_pkg::*;

	logic [7:0] paddle_x;
	logic dx, dy; // right, down
	logic move_r, move_l, on_paddle, ndx, ndy;
	coord_t nb;

	assign paddle_pos = '{paddle_x, 7'(`PADDLE_Y)};
	assign move_r = key_right && (paddle_x < 8'(`SCREEN_W - `PADDLE_W));
	assign move_l = key_left && (paddle_x > 8'd0);
	assign miss = (ball_pos.y >= 7'(`SCREEN_H));

	// next ball position and the bounces it causes
	always_comb begin
		nb.x = dx ? ball_pos.x + 8'd1 : ball_pos.x - 8'd1;
		nb.y = dy ? ball_pos.y + 7'd1 : ball_pos.y - 7'd1;
		on_paddle = dy
			&& (nb.y == 7'(`PADDLE_Y - 1) || nb.y == 7'(`PADDLE_Y))
			&& nb.x >= paddle_x
			&& nb.x <= paddle_x + 8'(`PADDLE_W - 1);
		ndx = dx ^ (nb.x == 8'd0 || nb.x >= 8'(`SCREEN_W - 1)) ^ on_paddle;
		ndy = dy ^ (nb.y == 7'd0) ^ on_paddle;
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst || init) begin
			paddle_x <= 8'(`PADDLE_X0);
			ball_pos <= '{8'(`BALL_X0), 7'(`BALL_Y0)};
			dx <= 1'b1; // up and right
			dy <= 1'b0;
		end else begin
			if (paddle_step)
				paddle_x <= paddle_x + {7'd0, move_r} - {7'd0, move_l};
			if (ball_step) begin
				ball_pos <= nb;
				dx <= ndx;
				dy <= ndy;
			end else if (hit) begin
				dy <= ~dy; // bounced off a block
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/block_field.sv
`default_nettype none
`include "breakout_macros.svh"

module block_field (
	input  wire logic                 CLOCK_50,
	input  wire logic                 rst,
	input  wire logic                 respawn,
	input  wire logic                 check,
	input  wire logic [3:0]           block_idx,
	input  wire breakout_pkg::coord_t ball_pos,
	output logic                      hit,
	output breakout_pkg::rect_t       block_rect,
	output logic                      all_clear,
	output logic [7:0]                score
);
	import breakout_pkg::*;

	logic [`NUM_BLOCKS-1:0] alive;
	block_def_t cur;
	logic in_block;

	assign cur = block_layout[block_idx];
	assign all_clear = ~|alive;

	assign in_block = alive[block_idx]
		&& ball_pos.y >= cur.origin.y
		&& ball_pos.y < cur.origin.y + 7'(`BLOCK_H)
		&& ball_pos.x >= cur.origin.x
		&& ball_pos.x < cur.origin.x + 8'(`BLOCK_W);

	assign block_rect = '{
		origin: cur.origin,
		w: 8'(`BLOCK_W),
		h: 7'(`BLOCK_H),
		colour: alive[block_idx] ? cur.colour : BLACK
	};

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			alive <= '1;
			score <= '0;
			hit <= 1'b0;
		end else begin
			hit <= 1'b0;
			if (respawn) begin
				alive <= '1;
				// board cleared means a win, score carries over
				if (!all_clear)
					score <= '0;
			end else if (check && in_block) begin
				alive[block_idx] <= 1'b0;
				score <= score + 8'd1;
				hit <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/rect_painter.sv
`default_nettype none

module rect_painter (
	input  wire logic                CLOCK_50,
	input  wire logic                rst,
	input  wire logic                paint_start,
	input  wire breakout_pkg::rect_t paint_req,
	output logic                     plot,
	output breakout_pkg::pixel_t     pix,
	output logic                     paint_done
);
	import breakout_pkg::*;

	rect_t req;
	logic busy;
	logic [7:0] col;
	logic [6:0] row;
	logic last_col, last_row;

	assign last_col = (col == req.w - 8'd1);
	assign last_row = (row == req.h - 7'd1);
	assign plot = busy;
	assign pix = '{'{req.origin.x + col, req.origin.y + row}, req.colour};

	always_ff @(posedge CLOCK_50) begin
		if (paint_start)
			req <= paint_req;
	end

	// row-major scan, one pixel per clock
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			busy <= 1'b0;
			col <= '0;
			row <= '0;
			paint_done <= 1'b0;
		end else begin
			paint_done <= 1'b0;
			if (paint_start) begin
				busy <= 1'b1;
				col <= '0;
				row <= '0;
			end else if (busy) begin
				if (last_col) begin
					col <= '0;
					if (last_row) begin
						busy <= 1'b0;
						paint_done <= 1'b1;
					end else begin
						row <= row + 7'd1;
					end
				end else begin
					col <= col + 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/score_display.sv
`default_nettype none

module score_display (
	input  wire logic       CLOCK_50,
	input  wire logic       rst,
	input  wire logic       game_over,
	input  wire logic [7:0] score,
	output logic [6:0]      hex0,
	output logic [6:0]      hex1,
	output logic [6:0]      hex4,
	output logic [6:0]      hex5,
	output logic [6:0]      hex6,
	output logic [6:0]      hex7
);

	logic [7:0] hi_score;
	logic over_q;

	// active low segments, g down to a
	function automatic logic [6:0] seg7(input logic [3:0] d);
		case (d)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'hA: return 7'b000_1000;
			4'hB: return 7'b000_0011;
			4'hC: return 7'b100_0110;
			4'hD: return 7'b010_0001;
			4'hE: return 7'b000_0110;
			default: return 7'b000_1110;
		endcase
	endfunction

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			hi_score <= '0;
			over_q <= 1'b0;
		end else begin
			over_q <= game_over;
			if (game_over && !over_q && score > hi_score)
				hi_score <= score;
		end
	end

	assign hex0 = seg7(score[3:0]);
	assign hex1 = seg7(score[7:4]);
	assign hex4 = seg7(hi_score[3:0]);
	assign hex5 = seg7(hi_score[7:4]);
	assign hex6 = 7'b100_1111; // I
	assign hex7 = 7'b000_1001; // H

endmodule

`default_nettype wire

//--- logic/breakout_top.sv
`default_nettype none

module breakout_top (
	input  wire logic            CLOCK_50,
	input  wire logic            rst,
	input  wire logic            new_game,
	input  wire logic            key_left,
	input  wire logic            key_right,
	output logic                 plot,
	output breakout_pkg::pixel_t pix,
	output logic                 game_over,
	output logic [6:0]           hex0,
	output logic [6:0]           hex1,
	output logic [6:0]           hex4,
	output logic [6:0]           hex5,
	output logic [6:0]           hex6,
	output logic [6:0]           hex7
);
	import breakout_pkg::*;

	logic paint_start, paint_done;
	logic init, respawn, paddle_step, ball_step, check;
	logic hit, miss, all_clear;
	logic [3:0] block_idx;
	logic [7:0] score;
	rect_t paint_req, block_rect;
	coord_t paddle_pos, ball_pos;

	game_fsm game_fsm_inst (
		.CLOCK_50(CLOCK_50), .rst(rst), .new_game(new_game),
		.paint_done(paint_done), .miss(miss), .all_clear(all_clear),
		.paddle_pos(paddle_pos), .ball_pos(ball_pos), .block_rect(block_rect),
		.paint_start(paint_start), .paint_req(paint_req),
		.init(init), .respawn(respawn), .paddle_step(paddle_step), .ball_step(ball_step),
		.check(check), .block_idx(block_idx), .game_over(game_over)
	);

	ball_paddle ball_paddle_inst (
		.CLOCK_50(CLOCK_50), .rst(rst), .init(init),
		.paddle_step(paddle_step), .ball_step(ball_step), .hit(hit),
		.key_left(key_left), .key_right(key_right),
		.paddle_pos(paddle_pos), .ball_pos(ball_pos), .miss(miss)
	);

	block_field block_field_inst (
		.CLOCK_50(CLOCK_50), .rst(rst), .respawn(respawn), .check(check),
		.block_idx(block_idx), .ball_pos(ball_pos),
		.hit(hit), .block_rect(block_rect), .all_clear(all_clear), .score(score)
	);

	rect_painter rect_painter_inst (
		.CLOCK_50(CLOCK_50), .rst(rst), .paint_start(paint_start), .paint_req(paint_req),
		.plot(plot), .pix(pix), .paint_done(paint_done)
	);

	score_display score_display_inst (
		.CLOCK_50(CLOCK_50), .rst(rst), .game_over(game_over), .score(score),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
	);

endmodule

`default_nettype wire

//--- tb/breakout_props.sv
`default_nettype none

module breakout_props (
	input wire logic                      CLOCK_50,
	input wire logic                      rst,
	input wire logic                      plot,
	input wire logic                      paint_start,
	input wire logic                      paint_done,
	input wire breakout_pkg::game_state_t state
);
	import breakout_pkg::*;

	// done is a single cycle strobe and moves the sequencer on
	done_one_cycle: assert property (@(posedge CLOCK_50) disable iff (rst)
		paint_done |=> !paint_done && state != $past(state))
		else $error("paint_done held longer than one cycle or not taken by the sequencer");

	no_plot_idle: assert property (@(posedge CLOCK_50) disable iff (rst)
		!(plot && state == S_IDLE))
		else $error("pixel plotted while sequencer idle");

	// no new request while the painter is still busy
	no_start_busy: assert property (@(posedge CLOCK_50) disable iff (rst)
		paint_start |-> !plot)
		else $error("paint_start issued during a paint");

endmodule

bind breakout_top breakout_props props_inst (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.plot(plot),
	.paint_start(paint_start),
	.paint_done(paint_done),
	.state(game_fsm_inst.state)
);

`default_nettype wire

//--- tb/breakout_tb.sv
`default_nettype none
`include "breakout_macros.svh"

module breakout_tb;
	import breakout_pkg::*;

	logic CLOCK_50, rst, new_game, key_left, key_right;
	logic plot, game_over;
	pixel_t pix;
	logic [6:0] hex0, hex1, hex4, hex5, hex6, hex7;

	int rec_cnt;
	int r_keys[32], r_ng[32], r_frames[32], r_pad[32], r_bx[32], r_by[32];
	int r_score[32], r_hi[32], r_go[32], r_blk[32];
	int cycles = 0;
	int limit = 0;

	// pixel stream decoding state
	int run_len = 0;
	int frames_seen = 0, clears = 0, red_fills = 0;
	int blk_cur = 0, blk_last = 0;
	int ball_x = 0, ball_y = 0, pad_x = 0;
	logic [7:0] first_x;
	logic [6:0] first_y;
	colour_t first_col;

	breakout_top breakout_top_inst (
		.CLOCK_50(CLOCK_50), .rst(rst), .new_game(new_game),
		.key_left(key_left), .key_right(key_right),
		.plot(plot), .pix(pix), .game_over(game_over),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .hex6(hex6), .hex7(hex7)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("TEST FAIL");
			$fatal(1, "timeout, no result after %0d clock cycles", limit);
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// active low, g down to a
	function automatic logic [6:0] seg_of(input logic [3:0] d);
		logic [6:0] on;
		case (d)
			4'h0: on = 7'h3f;
			4'h1: on = 7'h06;
			4'h2: on = 7'h5b;
			4'h3: on = 7'h4f;
			4'h4: on = 7'h66;
			4'h5: on = 7'h6d;
			4'h6: on = 7'h7d;
			4'h7: on = 7'h07;
			4'h8: on = 7'h7f;
			4'h9: on = 7'h67;
			4'ha: on = 7'h77;
			4'hb: on = 7'h7c;
			4'hc: on = 7'h39;
			4'hd: on = 7'h5e;
			4'he: on = 7'h79;
			default: on = 7'h71;
		endcase
		return ~on;
	endfunction

	// one run of plot = one rectangle
	always @(negedge CLOCK_50) begin
		if (plot) begin
			if (run_len == 0) begin
				first_x = pix.pos.x;
				first_y = pix.pos.y;
				first_col = pix.colour;
			end
			if (first_x == 0 && first_y == 0) begin // full screen fills
				check_val("fill_x", pix.pos.x, run_len % `SCREEN_W);
				check_val("fill_y", pix.pos.y, run_len / `SCREEN_W);
			end
			run_len = run_len + 1;
		end else if (run_len > 0) begin
			if (run_len == 1 && first_col == WHITE) begin
				ball_x = first_x;
				ball_y = first_y;
				blk_last = blk_cur;
				blk_cur = 0;
				frames_seen = frames_seen + 1;
			end else if (run_len == 2 * `PADDLE_W && first_col == WHITE && first_y == `PADDLE_Y)
				pad_x = first_x;
			else if (run_len == `BLOCK_W * `BLOCK_H
					&& (first_col == RED || first_col == CYAN || first_col == BLUE))
				blk_cur = blk_cur + 1;
			else if (run_len == `SCREEN_W * `SCREEN_H && first_col == BLACK)
				clears = clears + 1;
			else if (run_len == `SCREEN_W * `SCREEN_H && first_col == RED)
				red_fills = red_fills + 1;
			run_len = 0;
		end
	end

	task automatic read_golden();
		int fd, n;
		string line;
		fd = $fopen("tb/breakout_golden.txt", "r");
		if (fd == 0) begin
			$display("TEST FAIL");
			$fatal(1, "golden file could not be opened");
		end
		rec_cnt = 0;
		while (!$feof(fd) && rec_cnt < 32) begin
			n = $fgets(line, fd);
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", r_keys[rec_cnt], r_ng[rec_cnt],
				r_frames[rec_cnt], r_pad[rec_cnt], r_bx[rec_cnt], r_by[rec_cnt],
				r_score[rec_cnt], r_hi[rec_cnt], r_go[rec_cnt], r_blk[rec_cnt]);
			if (n == 10)
				rec_cnt++;
		end
		$fclose(fd);
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames_seen + n;
		while (frames_seen < target && !game_over) begin
			@(posedge CLOCK_50);
			#1;
		end
		@(posedge CLOCK_50); // hi score lands a cycle after game_over
		#1;
	endtask

	task automatic run_record(input int i);
		int fills_before;
		fills_before = red_fills;
		if (r_ng[i] != 0) begin
			new_game = 1'b1;
			@(posedge CLOCK_50);
			#1;
			new_game = 1'b0;
			wait_frames(1); // intro ball after the clear
			check_val("clears", clears, 2);
		end
		key_right = r_keys[i][0];
		key_left = r_keys[i][1];
		wait_frames(r_frames[i]);
		check_val("paddle_x", pad_x, r_pad[i]);
		check_val("ball_x", ball_x, r_bx[i]);
		check_val("ball_y", ball_y, r_by[i]);
		check_val("game_over", game_over, r_go[i]);
		check_val("blocks", game_over ? blk_cur : blk_last, r_blk[i]);
		check_val("red_fills", red_fills - fills_before, r_go[i]);
		check_val("hex0", hex0, seg_of(r_score[i] % 16));
		check_val("hex1", hex1, seg_of(r_score[i] / 16));
		check_val("hex4", hex4, seg_of(r_hi[i] % 16));
		check_val("hex5", hex5, seg_of(r_hi[i] / 16));
		check_val("hex6", hex6, 7'(~7'h30)); // I on e and f
		check_val("hex7", hex7, 7'(~7'h76)); // H on b c e f g
	endtask

	initial begin
		int total;
		rst = 1'b1;
		new_game = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		read_golden();
		total = 0;
		for (int i = 0; i < rec_cnt; i++)
			total += r_frames[i] + 2;
		limit = total * `FRAME_TICKS + 4 * `SCREEN_W * `SCREEN_H + 4096;

		repeat (4) @(posedge CLOCK_50);
		#1;
		rst = 1'b0;
		check_val("plot", plot, 1'b0);
		check_val("game_over", game_over, 1'b0);
		// start strobe first, pixel a cycle after it
		repeat (2) @(posedge CLOCK_50);
		#1;
		check_val("plot", plot, 1'b1);
		check_val("first_pix_x", pix.pos.x, 8'd0);
		check_val("first_pix_y", pix.pos.y, 7'd0);
		check_val("first_pix_colour", pix.colour, BLACK);
		wait_frames(1);
		check_val("clears", clears, 1);
		check_val("paddle_x", pad_x, `PADDLE_X0);
		check_val("ball_x", ball_x, `BALL_X0);
		check_val("ball_y", ball_y, `BALL_Y0);

		for (int i = 0; i < rec_cnt; i++)
			run_record(i);

		if (rec_cnt > 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "no records read from the golden file");
		end
	end

endmodule

`default_nettype wire

//--- tb/breakout_golden.txt
# keys(bit1 left, bit0 right) new_game frames | paddle_x ball_x ball_y score hi game_over blocks
# all decimal, each row continues the game of the row before it
0 0 1 76 81 107 0 0 0 10
1 0 10 86 91 97 0 0 0 10
1 0 70 144 157 27 0 0 0 10
2 0 150 0 7 47 1 0 0 9
0 0 62 0 55 109 1 0 0 9
0 0 11 0 65 119 1 1 1 9
0 1 1 76 81 107 0 1 0 10

//--- breakout_top.f
+incdir+logic
logic/breakout_pkg.sv
logic/game_fsm.sv
logic/ball_paddle.sv
logic/block_field.sv
logic/rect_painter.sv
logic/score_display.sv
logic/breakout_top.sv
tb/breakout_props.sv
tb/breakout_tb.sv
